// File: design/accel_pkg.sv
package accel_pkg;

	localparam int LANES    = 8;
	localparam int SAMPLE_W = 16;
	localparam int CTRL_W   = 5;

	typedef logic [LANES-1:0][SAMPLE_W-1:0] burst_t;	// lane 0 in the low bits

	localparam logic [2:0] OP_NOP  = 3'd0;
	localparam logic [2:0] OP_GEMM = 3'd1;

	// first word of a command
	typedef struct packed {
		logic [7:0] o_side;
		logic [7:0] i_side;
		logic [7:0] kernel;
		logic [3:0] stride;
		logic       rsvd;
		logic [2:0] op_type;
	} cmd_hdr_s;

	// second word of a command
	typedef struct packed {
		logic [15:0] o_channel;
		logic [15:0] i_channel;
	} cmd_chan_s;

	typedef union packed {
		cmd_hdr_s  hdr;
		cmd_chan_s chan;
	} cmd_word_u;

	localparam logic [1:0] PIPE_CMD    = 2'd0;
	localparam logic [1:0] PIPE_DATA   = 2'd1;
	localparam logic [1:0] PIPE_WEIGHT = 2'd2;
	localparam logic [1:0] PIPE_BIAS   = 2'd3;

	localparam logic [7:0] REG_CTRL     = 8'h00;
	localparam logic [7:0] REG_CMD_SIZE = 8'h04;
	localparam logic [7:0] REG_IRQ      = 8'h08;
	localparam logic [7:0] REG_HDR      = 8'h0C;
	localparam logic [7:0] REG_CHAN     = 8'h10;
	localparam logic [7:0] REG_DONE     = 8'h14;
	localparam logic [7:0] REG_GEMM     = 8'h18;
	localparam logic [7:0] REG_CMD_CNT  = 8'h1C;
	localparam logic [7:0] REG_RES_CNT  = 8'h20;

	localparam int CTRL_RAM_RST   = 0;
	localparam int CTRL_RES_FLUSH = 1;
	localparam int CTRL_CMD_FLUSH = 2;
	localparam int CTRL_SEQ_RST   = 3;
	localparam int CTRL_OP_EN     = 4;

endpackage

// File: design/accel_top.sv
`timescale 1ns/1ps

module accel_top #(
	parameter int FIFO_AW      = 5,
	parameter int READY_MARGIN = 4,
	parameter int D_AW         = 6,
	parameter int W_AW         = 9,
	parameter int B_AW         = 6
) (
	input  logic        okClk,
	input  logic        i_reset,
	// apb slave
	input  logic        i_psel,
	input  logic        i_penable,
	input  logic        i_pwrite,
	input  logic [7:0]  i_paddr,
	input  logic [31:0] i_pwdata,
	output logic [31:0] o_prdata,
	output logic        o_pready,
	output logic        o_pslverr,
	// host streams
	input  logic        i_pipe_write,
	input  logic [1:0]  i_pipe_sel,
	input  logic [31:0] i_pipe_data,
	output logic        o_pipe_ready,
	output logic        o_out_valid,
	output logic [31:0] o_out_data,
	input  logic        i_out_read,
	output logic        o_irq
);
	localparam int BURST_W = accel_pkg::LANES * accel_pkg::SAMPLE_W;

	logic [accel_pkg::CTRL_W-1:0] ctrl;
	logic [15:0]                  cmd_size;
	logic [15:0]                  done_count;
	logic [15:0]                  gemm_count;
	logic [FIFO_AW:0]             cmd_cnt;
	logic [FIFO_AW:0]             res_cnt;
	logic                         cmd_empty;
	logic                         cmd_read;
	logic [31:0]                  cmd_rdata;
	accel_pkg::cmd_word_u         hdr;
	accel_pkg::cmd_word_u         chan;
	logic                         res_write;
	logic                         res_full;
	logic                         res_empty;
	logic [31:0]                  res_data;
	logic                         d_we;
	logic                         w_we;
	logic                         b_we;
	logic [D_AW-1:0]              d_waddr;
	logic [W_AW-1:0]              w_waddr;
	logic [B_AW-1:0]              b_waddr;
	logic [BURST_W-1:0]           d_word;
	logic [BURST_W-1:0]           w_word;
	logic [31:0]                  b_word;

	cmd_if cmd_bus ();
	ram_rd_if #(.AW(D_AW), .DW(BURST_W)) d_rd ();
	ram_rd_if #(.AW(W_AW), .DW(BURST_W)) w_rd ();
	ram_rd_if #(.AW(B_AW), .DW(32))      b_rd ();

	assign o_out_valid = !res_empty;

	ctrl_regs #(.FIFO_AW(FIFO_AW)) u_regs (
		.okClk        (okClk),
		.i_reset      (i_reset),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.o_pready     (o_pready),
		.o_pslverr    (o_pslverr),
		.o_ctrl       (ctrl),
		.o_cmd_size   (cmd_size),
		.i_irq        (o_irq),
		.i_hdr        (hdr),
		.i_chan       (chan),
		.i_done_count (done_count),
		.i_gemm_count (gemm_count),
		.i_cmd_cnt    (cmd_cnt),
		.i_res_cnt    (res_cnt)
	);

	pipe_fifo #(.FIFO_AW(FIFO_AW), .READY_MARGIN(READY_MARGIN)) u_cmd_fifo (
		.okClk   (okClk),
		.i_reset (i_reset),
		.i_flush (ctrl[accel_pkg::CTRL_CMD_FLUSH]),
		.i_write (i_pipe_write && i_pipe_sel == accel_pkg::PIPE_CMD),
		.i_wdata (i_pipe_data),
		.i_read  (cmd_read),
		.o_rdata (cmd_rdata),
		.o_empty (cmd_empty),
		.o_full  (),
		.o_count (cmd_cnt),
		.o_ready (o_pipe_ready)
	);

	pipe_fifo #(.FIFO_AW(FIFO_AW), .READY_MARGIN(READY_MARGIN)) u_res_fifo (
		.okClk   (okClk),
		.i_reset (i_reset),
		.i_flush (ctrl[accel_pkg::CTRL_RES_FLUSH]),
		.i_write (res_write),
		.i_wdata (res_data),
		.i_read  (i_out_read),
		.o_rdata (o_out_data),
		.o_empty (res_empty),
		.o_full  (res_full),
		.o_count (res_cnt),
		.o_ready ()
	);

	burst_packer #(.AW(D_AW)) u_d_pack (
		.okClk      (okClk),
		.i_reset    (i_reset),
		.i_addr_rst (ctrl[accel_pkg::CTRL_RAM_RST]),
		.i_write    (i_pipe_write && i_pipe_sel == accel_pkg::PIPE_DATA),
		.i_sample   (i_pipe_data[15:0]),
		.o_we       (d_we),
		.o_addr     (d_waddr),
		.o_word     (d_word)
	);

	burst_packer #(.AW(W_AW)) u_w_pack (
		.okClk      (okClk),
		.i_reset    (i_reset),
		.i_addr_rst (ctrl[accel_pkg::CTRL_RAM_RST]),
		.i_write    (i_pipe_write && i_pipe_sel == accel_pkg::PIPE_WEIGHT),
		.i_sample   (i_pipe_data[15:0]),
		.o_we       (w_we),
		.o_addr     (w_waddr),
		.o_word     (w_word)
	);

	// bias words are whole, one per write
	burst_packer #(.AW(B_AW), .LANE_N(1), .LANE_W(32)) u_b_pack (
		.okClk      (okClk),
		.i_reset    (i_reset),
		.i_addr_rst (ctrl[accel_pkg::CTRL_RAM_RST]),
		.i_write    (i_pipe_write && i_pipe_sel == accel_pkg::PIPE_BIAS),
		.i_sample   (i_pipe_data),
		.o_we       (b_we),
		.o_addr     (b_waddr),
		.o_word     (b_word)
	);

	vector_ram #(.AW(D_AW), .DW(BURST_W)) u_d_ram (
		.okClk   (okClk),
		.i_we    (d_we),
		.i_waddr (d_waddr),
		.i_wdata (d_word),
		.rd      (d_rd.target)
	);

	vector_ram #(.AW(W_AW), .DW(BURST_W)) u_w_ram (
		.okClk   (okClk),
		.i_we    (w_we),
		.i_waddr (w_waddr),
		.i_wdata (w_word),
		.rd      (w_rd.target)
	);

	vector_ram #(.AW(B_AW), .DW(32)) u_b_ram (
		.okClk   (okClk),
		.i_we    (b_we),
		.i_waddr (b_waddr),
		.i_wdata (b_word),
		.rd      (b_rd.target)
	);

	cmd_sequencer u_seq (
		.okClk        (okClk),
		.i_reset      (i_reset || ctrl[accel_pkg::CTRL_SEQ_RST]),
		.i_op_en      (ctrl[accel_pkg::CTRL_OP_EN]),
		.i_cmd_size   (cmd_size),
		.i_fifo_empty (cmd_empty),
		.i_fifo_data  (cmd_rdata),
		.o_fifo_read  (cmd_read),
		.cmd          (cmd_bus.initiator),
		.o_hdr        (hdr),
		.o_chan       (chan),
		.o_done_count (done_count),
		.o_irq        (o_irq)
	);

	gemm_engine #(.D_AW(D_AW), .W_AW(W_AW), .B_AW(B_AW)) u_engine (
		.okClk        (okClk),
		.i_reset      (i_reset || ctrl[accel_pkg::CTRL_SEQ_RST]),
		.cmd          (cmd_bus.target),
		.d_rd         (d_rd.initiator),
		.w_rd         (w_rd.initiator),
		.b_rd         (b_rd.initiator),
		.i_res_full   (res_full),
		.o_res_write  (res_write),
		.o_res_data   (res_data),
		.o_gemm_count (gemm_count)
	);

endmodule

// File: design/burst_packer.sv
`timescale 1ns/1ps

module burst_packer #(
	parameter int AW     = 6,
	parameter int LANE_N = accel_pkg::LANES,
	parameter int LANE_W = accel_pkg::SAMPLE_W
) (
	input  logic                     okClk,
	input  logic                     i_reset,
	input  logic                     i_addr_rst,
	input  logic                     i_write,
	input  logic [LANE_W-1:0]        i_sample,
	output logic                     o_we,
	output logic [AW-1:0]            o_addr,
	output logic [LANE_N*LANE_W-1:0] o_word
);
	localparam int LW = (LANE_N > 1) ? $clog2(LANE_N) : 1;

	logic [LW-1:0] lane;
	logic          last;

	assign last = (lane == LW'(LANE_N - 1));
	assign o_we = i_write && last;	// word goes out with its final sample

	always_ff @(posedge okClk) begin
		if (i_reset || i_addr_rst) begin
			lane   <= '0;
			o_addr <= '0;
		end else if (i_write) begin
			if (last) begin
				lane   <= '0;
				o_addr <= o_addr + 1'b1;
			end else begin
				lane <= lane + 1'b1;
			end
		end
	end

	generate
		if (LANE_N > 1) begin : g_shift
			logic [(LANE_N-1)*LANE_W-1:0] held;	// earlier samples of the word

			assign o_word = {i_sample, held};

			always_ff @(posedge okClk) begin
				if (i_write)
					held <= o_word[LANE_N*LANE_W-1:LANE_W];
			end
		end else begin : g_single
			assign o_word = i_sample;	// one sample per word, e.g. bias
		end
	endgenerate

endmodule

// File: design/cmd_sequencer.sv
`timescale 1ns/1ps

interface cmd_if;
	logic        valid;
	logic        ready;
	logic        done;
	logic [2:0]  op_type;
	logic [15:0] i_channel;
	logic [15:0] o_channel;

	modport initiator (output valid, op_type, i_channel, o_channel, input ready, done);
	modport target (input valid, op_type, i_channel, o_channel, output ready, done);
endinterface

module cmd_sequencer (
	input  logic                 okClk,
	input  logic                 i_reset,
	input  logic                 i_op_en,
	input  logic [15:0]          i_cmd_size,
	input  logic                 i_fifo_empty,
	input  accel_pkg::cmd_word_u i_fifo_data,
	output logic                 o_fifo_read,
	cmd_if.initiator             cmd,
	output accel_pkg::cmd_word_u o_hdr,
	output accel_pkg::cmd_word_u o_chan,
	output logic [15:0]          o_done_count,
	output logic                 o_irq
);
	localparam logic [1:0] S_HDR   = 2'd0;
	localparam logic [1:0] S_CHAN  = 2'd1;
	localparam logic [1:0] S_ISSUE = 2'd2;
	localparam logic [1:0] S_WAIT  = 2'd3;

	logic [1:0] state;

	// op_en only gates the header, a started command always completes
	assign o_fifo_read = !i_fifo_empty &&
		((state == S_HDR && i_op_en) || state == S_CHAN);

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			state        <= S_HDR;
			o_hdr        <= '0;
			o_chan       <= '0;
			o_done_count <= '0;
		end else begin
			case (state)
				S_HDR: begin
					if (o_fifo_read) begin
						o_hdr <= i_fifo_data;
						state <= S_CHAN;
					end
				end
				S_CHAN: begin
					if (o_fifo_read) begin
						o_chan <= i_fifo_data;
						state  <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (cmd.ready)
						state <= S_WAIT;	// handshake taken
				end
				default: begin
					if (cmd.done)
						state <= S_HDR;
				end
			endcase
			if (cmd.done)
				o_done_count <= o_done_count + 1'b1;
		end
	end

	assign cmd.valid     = (state == S_ISSUE);
	assign cmd.op_type   = o_hdr.hdr.op_type;
	assign cmd.i_channel = o_chan.chan.i_channel;
	assign cmd.o_channel = o_chan.chan.o_channel;

	assign o_irq = (i_cmd_size != '0) && (o_done_count == i_cmd_size);

endmodule

// File: design/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs #(
	parameter int FIFO_AW = 5
) (
	input  logic                         okClk,
	input  logic                         i_reset,
	input  logic                         i_psel,
	input  logic                         i_penable,
	input  logic                         i_pwrite,
	input  logic [7:0]                   i_paddr,
	input  logic [31:0]                  i_pwdata,
	output logic [31:0]                  o_prdata,
	output logic                         o_pready,
	output logic                         o_pslverr,
	output logic [accel_pkg::CTRL_W-1:0] o_ctrl,
	output logic [15:0]                  o_cmd_size,
	input  logic                         i_irq,
	input  accel_pkg::cmd_word_u         i_hdr,
	input  accel_pkg::cmd_word_u         i_chan,
	input  logic [15:0]                  i_done_count,
	input  logic [15:0]                  i_gemm_count,
	input  logic [FIFO_AW:0]             i_cmd_cnt,
	input  logic [FIFO_AW:0]             i_res_cnt
);
	logic wr_en;
	logic known;

	assign wr_en = i_psel && i_penable && i_pwrite;

	always_comb begin
		known    = 1'b1;
		o_prdata = '0;
		case (i_paddr)
			accel_pkg::REG_CTRL:     o_prdata = 32'(o_ctrl);
			accel_pkg::REG_CMD_SIZE: o_prdata = 32'(o_cmd_size);
			accel_pkg::REG_IRQ:      o_prdata = 32'(i_irq);
			accel_pkg::REG_HDR:      o_prdata = i_hdr;
			accel_pkg::REG_CHAN:     o_prdata = i_chan;
			accel_pkg::REG_DONE:     o_prdata = 32'(i_done_count);
			accel_pkg::REG_GEMM:     o_prdata = 32'(i_gemm_count);
			accel_pkg::REG_CMD_CNT:  o_prdata = 32'(i_cmd_cnt);
			accel_pkg::REG_RES_CNT:  o_prdata = 32'(i_res_cnt);
			default:                 known = 1'b0;
		endcase
	end

	assign o_pready  = 1'b1;	// zero wait states
	assign o_pslverr = i_psel && i_penable && !known;

	// only ctrl and cmd size are writable, status writes are ignored
	always_ff @(posedge okClk) begin
		if (i_reset) begin
			o_ctrl     <= '0;
			o_cmd_size <= '0;
		end else if (wr_en) begin
			case (i_paddr)
				accel_pkg::REG_CTRL:     o_ctrl <= i_pwdata[accel_pkg::CTRL_W-1:0];
				accel_pkg::REG_CMD_SIZE: o_cmd_size <= i_pwdata[15:0];
				default: ;
			endcase
		end
	end

endmodule

// File: design/gemm_engine.sv
`timescale 1ns/1ps

module gemm_engine #(
	parameter int D_AW = 6,
	parameter int W_AW = 9,
	parameter int B_AW = 6
) (
	input  logic        okClk,
	input  logic        i_reset,
	cmd_if.target       cmd,
	ram_rd_if.initiator d_rd,
	ram_rd_if.initiator w_rd,
	ram_rd_if.initiator b_rd,
	input  logic        i_res_full,
	output logic        o_res_write,
	output logic [31:0] o_res_data,
	output logic [15:0] o_gemm_count
);
	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_BIAS  = 3'd1;
	localparam logic [2:0] S_MAC   = 3'd2;
	localparam logic [2:0] S_WRITE = 3'd3;
	localparam logic [2:0] S_DONE  = 3'd4;

	logic [2:0]         state;
	logic [2:0]         op;
	logic [15:0]        k_total;	// bursts per output channel
	logic [15:0]        n_total;
	logic [15:0]        k_idx;
	logic [15:0]        n_idx;
	logic [W_AW-1:0]    w_base;	// n * K
	logic               rd_vld;	// a burst read lands this cycle
	logic               first;	// bias lands this cycle
	logic [31:0]        acc;
	logic signed [31:0] dot;
	accel_pkg::burst_t  d_word;
	accel_pkg::burst_t  w_word;

	assign d_word    = d_rd.rdata;
	assign w_word    = w_rd.rdata;
	assign d_rd.addr = k_idx[D_AW-1:0];
	assign w_rd.addr = w_base + k_idx[W_AW-1:0];
	assign b_rd.addr = n_idx[B_AW-1:0];

	always_comb begin
		dot = '0;
		for (int l = 0; l < accel_pkg::LANES; l++)
			dot = dot + $signed(d_word[l]) * $signed(w_word[l]);
	end

	assign cmd.ready   = (state == S_IDLE);
	assign cmd.done    = (state == S_DONE);
	assign o_res_write = (state == S_WRITE) && !i_res_full;	// stall while full
	assign o_res_data  = acc;

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			state        <= S_IDLE;
			rd_vld       <= 1'b0;
			first        <= 1'b0;
			k_idx        <= '0;
			n_idx        <= '0;
			w_base       <= '0;
			o_gemm_count <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (cmd.valid) begin
						op      <= cmd.op_type;
						k_total <= cmd.i_channel >> $clog2(accel_pkg::LANES);
						n_total <= cmd.o_channel;
						k_idx   <= '0;
						n_idx   <= '0;
						w_base  <= '0;
						if (cmd.op_type == accel_pkg::OP_GEMM && cmd.o_channel != '0)
							state <= S_BIAS;
						else
							state <= S_DONE;
					end
				end
				S_BIAS: begin
					// bias and burst 0 are both being read now
					rd_vld <= (k_total != '0);
					k_idx  <= k_idx + 1'b1;
					first  <= 1'b1;
					state  <= S_MAC;
				end
				S_MAC: begin
					acc   <= (first ? b_rd.rdata : acc) + (rd_vld ? $unsigned(dot) : 32'd0);
					first <= 1'b0;
					if (k_idx < k_total) begin
						k_idx  <= k_idx + 1'b1;	// next read in flight
						rd_vld <= 1'b1;
					end else begin
						rd_vld <= 1'b0;
					end
					if (!rd_vld && !first)
						state <= S_WRITE;
				end
				S_WRITE: begin
					if (!i_res_full) begin
						n_idx  <= n_idx + 1'b1;
						k_idx  <= '0;
						w_base <= w_base + k_total[W_AW-1:0];
						state  <= (n_idx == n_total - 1'b1) ? S_DONE : S_BIAS;
					end
				end
				S_DONE: begin
					if (op == accel_pkg::OP_GEMM)
						o_gemm_count <= o_gemm_count + 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: design/pipe_fifo.sv
`timescale 1ns/1ps

module pipe_fifo #(
	parameter int FIFO_AW      = 5,
	parameter int READY_MARGIN = 4
) (
	input  logic               okClk,
	input  logic               i_reset,
	input  logic               i_flush,
	input  logic               i_write,
	input  logic [31:0]        i_wdata,
	input  logic               i_read,
	output logic [31:0]        o_rdata,
	output logic               o_empty,
	output logic               o_full,
	output logic [FIFO_AW:0]   o_count,
	output logic               o_ready
);
	localparam int DEPTH = 2 ** FIFO_AW;

	logic [31:0]        mem [DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic               do_wr;
	logic               do_rd;

	assign do_wr = i_write && !o_full;	// writes while full are dropped
	assign do_rd = i_read && !o_empty;

	always_ff @(posedge okClk) begin
		if (i_reset || i_flush) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				o_count <= o_count + 1'b1;
			else if (do_rd && !do_wr)
				o_count <= o_count - 1'b1;
		end
	end

	always_ff @(posedge okClk) begin
		if (do_wr)
			mem[wr_ptr] <= i_wdata;
	end

	assign o_rdata = mem[rd_ptr];	// head shown ahead of the read
	assign o_empty = (o_count == '0);
	assign o_full  = (o_count == DEPTH);

	// throttle against a reduced size so the writer keeps some slack
	assign o_ready = (DEPTH - o_count) > READY_MARGIN;

endmodule

// File: design/vector_ram.sv
`timescale 1ns/1ps

interface ram_rd_if #(
	parameter int AW = 6,
	parameter int DW = 128
);
	logic [AW-1:0] addr;
	logic [DW-1:0] rdata;

	modport initiator (output addr, input rdata);
	modport target (input addr, output rdata);
endinterface

module vector_ram #(
	parameter int AW = 6,
	parameter int DW = 128
) (
	input  logic          okClk,
	input  logic          i_we,
	input  logic [AW-1:0] i_waddr,
	input  logic [DW-1:0] i_wdata,
	ram_rd_if.target      rd
);
	logic [DW-1:0] mem [2**AW];

	always_ff @(posedge okClk) begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
		rd.rdata <= mem[rd.addr];	// one cycle read
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module accel_tb -o accel_sim

out=$(./obj_dir/accel_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1

// File: tb/accel_tb.sv
`timescale 1ns/1ps

module accel_tb;
	localparam int FIFO_AW      = 5;
	localparam int READY_MARGIN = 4;
	localparam int D_AW         = 6;
	localparam int W_AW         = 9;
	localparam int B_AW         = 6;
	localparam int WAIT_LIMIT   = 2000;	// cycles
	localparam int POLL_LIMIT   = 500;	// register reads
	localparam int N_CMDS       = 8;

	typedef struct packed {
		logic [2:0]  op;
		logic [15:0] i_ch;
		logic [15:0] o_ch;
		logic        hold;	// leave results undrained until the fifo fills
	} cmd_entry_t;

	localparam cmd_entry_t CMD_TABLE [N_CMDS] = '{
		'{accel_pkg::OP_GEMM, 16'd32, 16'd4,  1'b0},
		'{accel_pkg::OP_NOP,  16'd16, 16'd8,  1'b0},
		'{accel_pkg::OP_GEMM, 16'd8,  16'd6,  1'b0},
		'{accel_pkg::OP_GEMM, 16'd20, 16'd3,  1'b0},	// K rounds down to 2
		'{accel_pkg::OP_GEMM, 16'd0,  16'd2,  1'b0},	// bias only
		'{accel_pkg::OP_NOP,  16'd0,  16'd0,  1'b0},
		'{accel_pkg::OP_GEMM, 16'd8,  16'd40, 1'b1},
		'{accel_pkg::OP_GEMM, 16'd16, 16'd5,  1'b0}
	};

	logic        okClk;
	logic        i_reset;
	logic        i_psel;
	logic        i_penable;
	logic        i_pwrite;
	logic [7:0]  i_paddr;
	logic [31:0] i_pwdata;
	logic [31:0] o_prdata;
	logic        o_pready;
	logic        o_pslverr;
	logic        i_pipe_write;
	logic [1:0]  i_pipe_sel;
	logic [31:0] i_pipe_data;
	logic        o_pipe_ready;
	logic        o_out_valid;
	logic [31:0] o_out_data;
	logic        i_out_read;
	logic        o_irq;

	logic [31:0]       lfsr = 32'h625a_cc0c;
	int                done_exp = 0;
	accel_pkg::burst_t d_mem [2**D_AW];	// model copies of the three RAMs
	accel_pkg::burst_t w_mem [2**W_AW];
	logic [31:0]       b_mem [2**B_AW];

	clk_gen #(.HALF_PERIOD(4), .RESET_CYCLES(10)) u_clk (
		.o_clk   (okClk),
		.o_reset (i_reset)
	);

	accel_top #(
		.FIFO_AW      (FIFO_AW),
		.READY_MARGIN (READY_MARGIN),
		.D_AW         (D_AW),
		.W_AW         (W_AW),
		.B_AW         (B_AW)
	) u_dut (
		.okClk        (okClk),
		.i_reset      (i_reset),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.o_pready     (o_pready),
		.o_pslverr    (o_pslverr),
		.i_pipe_write (i_pipe_write),
		.i_pipe_sel   (i_pipe_sel),
		.i_pipe_data  (i_pipe_data),
		.o_pipe_ready (o_pipe_ready),
		.o_out_valid  (o_out_valid),
		.o_out_data   (o_out_data),
		.i_out_read   (i_out_read),
		.o_irq        (o_irq)
	);

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "stopping at first error");
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
		end
		return v;
	endfunction

	// bias plus lane-wise signed dot products, 32-bit wrap
	function automatic logic [31:0] model_result(input int n, input int k_cnt);
		int acc;
		int a;
		int b;
		acc = int'(b_mem[n]);
		for (int k = 0; k < k_cnt; k++) begin
			for (int l = 0; l < accel_pkg::LANES; l++) begin
				a   = $signed(d_mem[k][l]);
				b   = $signed(w_mem[n * k_cnt + k][l]);
				acc = acc + a * b;
			end
		end
		return acc;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch at %0t: %s got 0x%08h expected 0x%08h",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_hdr(input string name, input accel_pkg::cmd_word_u got,
			input accel_pkg::cmd_word_u exp);
		if (got !== exp)
			stop_with_error($sformatf(
				"Mismatch at %0t: %s got 0x%08h (op %0d) expected 0x%08h (op %0d)",
				$time, name, got, got.hdr.op_type, exp, exp.hdr.op_type));
	endtask

	task automatic check_chan(input string name, input accel_pkg::cmd_word_u got,
			input accel_pkg::cmd_word_u exp);
		if (got !== exp)
			stop_with_error($sformatf(
				"Mismatch at %0t: %s got out %0d in %0d expected out %0d in %0d",
				$time, name, got.chan.o_channel, got.chan.i_channel,
				exp.chan.o_channel, exp.chan.i_channel));
	endtask

	task automatic wait_pready();
		int t;
		t = 0;
		@(negedge okClk);
		while (!o_pready && t < WAIT_LIMIT) begin
			@(negedge okClk);
			t++;
		end
		if (!o_pready)
			stop_with_error("APB slave never raised pready");
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge okClk);
		i_psel    <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite  <= 1'b1;
		i_paddr   <= addr;
		i_pwdata  <= data;
		@(posedge okClk);
		i_penable <= 1'b1;
		wait_pready();
		@(posedge okClk);
		i_psel    <= 1'b0;
		i_penable <= 1'b0;
		i_pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(posedge okClk);
		i_psel    <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite  <= 1'b0;
		i_paddr   <= addr;
		@(posedge okClk);
		i_penable <= 1'b1;
		wait_pready();
		data = o_prdata;	// access phase, mid cycle
		err  = o_pslverr;
		@(posedge okClk);
		i_psel    <= 1'b0;
		i_penable <= 1'b0;
	endtask

	task automatic reg_expect(input logic [7:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] rd;
		logic        err;
		apb_read(addr, rd, err);
		check_bit({name, " pslverr"}, err, 1'b0);
		check_word(name, rd, exp);
	endtask

	task automatic poll_reg(input logic [7:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] rd;
		logic        err;
		int          t;
		rd = ~exp;
		t  = 0;
		while (rd !== exp && t < POLL_LIMIT) begin
			apb_read(addr, rd, err);
			t++;
		end
		if (rd !== exp)
			stop_with_error($sformatf("timeout waiting for %s to reach %0d, last read %0d",
				name, exp, rd));
	endtask

	task automatic pipe_put(input logic [1:0] sel, input logic [31:0] data);
		int t;
		t = 0;
		@(negedge okClk);
		while (!o_pipe_ready && t < WAIT_LIMIT) begin
			@(negedge okClk);
			t++;
		end
		if (!o_pipe_ready)
			stop_with_error("command stream never became ready");
		@(posedge okClk);
		i_pipe_write <= 1'b1;
		i_pipe_sel   <= sel;
		i_pipe_data  <= data;
		@(posedge okClk);
		i_pipe_write <= 1'b0;
	endtask

	task automatic load_vectors(input int nd, input int nw, input int nb);
		logic [15:0] s;
		logic [31:0] b;
		for (int i = 0; i < nd; i++) begin
			for (int l = 0; l < accel_pkg::LANES; l++) begin
				s          = 16'(rand_bits(16));
				d_mem[i][l] = s;
				pipe_put(accel_pkg::PIPE_DATA, {~s, s});	// upper half is ignored
			end
		end
		for (int i = 0; i < nw; i++) begin
			for (int l = 0; l < accel_pkg::LANES; l++) begin
				s          = 16'(rand_bits(16));
				w_mem[i][l] = s;
				pipe_put(accel_pkg::PIPE_WEIGHT, {~s, s});
			end
		end
		for (int i = 0; i < nb; i++) begin
			b        = rand_bits(32);
			b_mem[i] = b;
			pipe_put(accel_pkg::PIPE_BIAS, b);
		end
	endtask

	task automatic drain_result(input int n, input logic [31:0] exp);
		int t;
		t = 0;
		@(negedge okClk);
		while (!o_out_valid && t < WAIT_LIMIT) begin
			@(negedge okClk);
			t++;
		end
		if (!o_out_valid)
			stop_with_error($sformatf("timeout waiting for result %0d", n));
		check_word($sformatf("o_out_data[%0d]", n), o_out_data, exp);
		@(posedge okClk);
		i_out_read <= 1'b1;
		@(posedge okClk);
		i_out_read <= 1'b0;
	endtask

	task automatic run_entry(input cmd_entry_t e);
		accel_pkg::cmd_word_u hdr_w;
		accel_pkg::cmd_word_u chan_w;
		logic [31:0]          rd;
		logic                 err;
		int                   k_cnt;
		hdr_w.hdr.o_side       = 8'(rand_bits(8));
		hdr_w.hdr.i_side       = 8'(rand_bits(8));
		hdr_w.hdr.kernel       = 8'(rand_bits(8));
		hdr_w.hdr.stride       = 4'(rand_bits(4));
		hdr_w.hdr.rsvd         = 1'b0;
		hdr_w.hdr.op_type      = e.op;
		chan_w.chan.o_channel  = e.o_ch;
		chan_w.chan.i_channel  = e.i_ch;
		k_cnt = e.i_ch / accel_pkg::LANES;
		pipe_put(accel_pkg::PIPE_CMD, hdr_w);
		pipe_put(accel_pkg::PIPE_CMD, chan_w);
		if (e.hold) begin
			poll_reg(accel_pkg::REG_RES_CNT, 2**FIFO_AW, "REG_RES_CNT");
			reg_expect(accel_pkg::REG_DONE, done_exp, "REG_DONE while stalled");
		end
		if (e.op == accel_pkg::OP_GEMM) begin
			for (int n = 0; n < e.o_ch; n++)
				drain_result(n, model_result(n, k_cnt));
		end
		done_exp++;
		poll_reg(accel_pkg::REG_DONE, done_exp, "REG_DONE");
		@(negedge okClk);
		check_bit("o_out_valid", o_out_valid, 1'b0);	// nothing beyond o_channel results
		check_bit("o_irq", o_irq, done_exp == N_CMDS);
		reg_expect(accel_pkg::REG_IRQ, done_exp == N_CMDS, "REG_IRQ");
		apb_read(accel_pkg::REG_HDR, rd, err);
		check_hdr("REG_HDR", rd, hdr_w);
		apb_read(accel_pkg::REG_CHAN, rd, err);
		check_chan("REG_CHAN", rd, chan_w);
	endtask

	initial begin
		logic [31:0] rd;
		logic        err;
		int          t;
		int          gemm_exp;
		cmd_entry_t  extra;
		i_psel       <= 1'b0;
		i_penable    <= 1'b0;
		i_pwrite     <= 1'b0;
		i_paddr      <= '0;
		i_pwdata     <= '0;
		i_pipe_write <= 1'b0;
		i_pipe_sel   <= '0;
		i_pipe_data  <= '0;
		i_out_read   <= 1'b0;
		t = 0;
		while (i_reset !== 1'b0 && t < WAIT_LIMIT) begin
			@(negedge okClk);
			t++;
		end
		if (i_reset !== 1'b0)
			stop_with_error("reset was never released");

		// state right after reset
		@(negedge okClk);
		check_bit("o_irq", o_irq, 1'b0);
		check_bit("o_out_valid", o_out_valid, 1'b0);
		check_bit("o_pipe_ready", o_pipe_ready, 1'b1);
		for (int a = 0; a <= 32; a += 4)
			reg_expect(8'(a), 32'd0, $sformatf("reg 0x%02h", a));
		apb_read(8'h24, rd, err);
		check_bit("o_pslverr at 0x24", err, 1'b1);

		apb_write(accel_pkg::REG_CMD_SIZE, N_CMDS);
		reg_expect(accel_pkg::REG_CMD_SIZE, N_CMDS, "REG_CMD_SIZE");
		load_vectors(4, 64, 40);
		apb_write(accel_pkg::REG_CTRL, 32'(1) << accel_pkg::CTRL_OP_EN);
		reg_expect(accel_pkg::REG_CTRL, 32'(1) << accel_pkg::CTRL_OP_EN, "REG_CTRL");

		gemm_exp = 0;
		for (int i = 0; i < N_CMDS; i++) begin
			run_entry(CMD_TABLE[i]);
			if (CMD_TABLE[i].op == accel_pkg::OP_GEMM)
				gemm_exp++;
		end
		reg_expect(accel_pkg::REG_GEMM, gemm_exp, "REG_GEMM");

		// rewind the write addresses and compute from fresh data
		apb_write(accel_pkg::REG_CTRL, (32'(1) << accel_pkg::CTRL_OP_EN) |
			(32'(1) << accel_pkg::CTRL_RAM_RST));
		apb_write(accel_pkg::REG_CTRL, 32'(1) << accel_pkg::CTRL_OP_EN);
		load_vectors(4, 16, 4);
		extra = '{accel_pkg::OP_GEMM, 16'd32, 16'd4, 1'b0};
		run_entry(extra);

		// irq raised again so the sequencer reset has something to clear
		apb_write(accel_pkg::REG_CMD_SIZE, done_exp);
		@(negedge okClk);
		check_bit("o_irq before sequencer reset", o_irq, 1'b1);

		apb_write(accel_pkg::REG_CTRL, 32'(1) << accel_pkg::CTRL_SEQ_RST);
		reg_expect(accel_pkg::REG_DONE, 32'd0, "REG_DONE after sequencer reset");
		reg_expect(accel_pkg::REG_IRQ, 32'd0, "REG_IRQ after sequencer reset");
		@(negedge okClk);
		check_bit("o_irq", o_irq, 1'b0);

		$display("No errors");
		$finish;
	end

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clk,
	output logic o_reset
);
	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_reset <= 1'b0;	// released on an edge like any driven input
	end

endmodule

// File: vlog.f
design/accel_pkg.sv
design/pipe_fifo.sv
design/vector_ram.sv
design/burst_packer.sv
design/cmd_sequencer.sv
design/gemm_engine.sv
design/ctrl_regs.sv
design/accel_top.sv
tb/clk_gen.sv
tb/accel_tb.sv
